/* Bender.yml */
package:
  name: l1_bus_interface

sources:
  # package first, then leaf modules, then the top level
  - src/bus_if_pkg.sv
  - src/line_serializer.sv
  - src/line_deserializer.sv
  - src/request_sequencer.sv
  - src/l1_bus_interface.sv

  - target: test
    files:
      - bench/tb_l1_bus_interface.sv

/* bench/tb_l1_bus_interface.sv */
// testbench for l1_bus_interface with clock, reset, LFSR, stimulus table, memory responder and checks
`timescale 1ns/10ps

module tb_l1_bus_interface;

    localparam int num_rows       = 6;
    localparam int reset_cycles   = 4;
    localparam int timeout_margin = 20;
    localparam int lfsr_width     = 16;

    typedef struct packed {
        bus_if_pkg::msg_t   msg;
        logic [31:0]        address;
        bus_if_pkg::line_t  data;         // line to write back or response line for a read
        int                 grant_delay;
        int                 resp_delay;
        bit                 stray;        // second strobe while busy
    } row_t;

    logic                                  clock = 1'b0;
    logic                                  reset;
    bus_if_pkg::msg_t                      cache_msg_in;
    logic [bus_if_pkg::address_width-1:0]  cache_address_in;
    bus_if_pkg::line_t                     cache_data_in;
    bus_if_pkg::msg_t                      cache_msg_out;
    logic [bus_if_pkg::address_width-1:0]  cache_address_out;
    bus_if_pkg::line_t                     cache_data_out;
    bus_if_pkg::msg_t                      bus_msg_in;
    bus_if_pkg::beat_t                     bus_data_in;
    logic                                  bus_master;
    bus_if_pkg::msg_t                      bus_msg_out;
    logic [bus_if_pkg::address_width-1:0]  bus_address_out;
    bus_if_pkg::beat_t                     bus_data_out;

    row_t                   rows [num_rows];
    logic [lfsr_width-1:0]  lfsr_state;
    int                     error_count = 0;
    int                     check_count = 0;
    int                     row_errors;
    int                     cycle_count = 0;
    int                     cycle_limit = 1000000;

    l1_bus_interface i_l1_bus_interface (
        .clock             (clock),
        .reset             (reset),
        .cache_msg_in      (cache_msg_in),
        .cache_address_in  (cache_address_in),
        .cache_data_in     (cache_data_in),
        .cache_msg_out     (cache_msg_out),
        .cache_address_out (cache_address_out),
        .cache_data_out    (cache_data_out),
        .bus_msg_in        (bus_msg_in),
        .bus_data_in       (bus_data_in),
        .bus_master        (bus_master),
        .bus_msg_out       (bus_msg_out),
        .bus_address_out   (bus_address_out),
        .bus_data_out      (bus_data_out)
    );

    always #2 clock = ~clock;  // 4 ns period

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // taps for x^16 + x^14 + x^13 + x^11 with the new bit entering at the bottom
    function automatic logic [lfsr_width-1:0] lfsr_next(input logic [lfsr_width-1:0] s);
        logic feedback;
        feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[lfsr_width-2:0], feedback};
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            row_errors++;
            $display("Error: at %0t ns, %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic set_row(input int idx, input bus_if_pkg::msg_t msg, input logic [31:0] address,
                           input int grant_delay, input int resp_delay, input bit stray);
        logic [127:0] data;
        for (int b = 0; b < 128; b++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            data[b]    = lfsr_state[0];
        end
        rows[idx].msg         = msg;
        rows[idx].address     = address;
        rows[idx].data        = data;
        rows[idx].grant_delay = grant_delay;
        rows[idx].resp_delay  = resp_delay;
        rows[idx].stray       = stray;
    endtask

    // memory model that grants after the row's delay and then acks or sends two read beats
    task automatic respond_row(input int idx);
        logic [127:0] flat;
        flat = rows[idx].data;
        do @(negedge clock); while (bus_msg_out == bus_if_pkg::no_req);
        repeat (rows[idx].grant_delay) @(negedge clock);
        bus_master = 1'b1;
        @(negedge clock);
        bus_master = 1'b0;
        if (rows[idx].msg == bus_if_pkg::wb_req) begin
            repeat (2 + rows[idx].resp_delay) @(negedge clock);  // both beats are out by now
            bus_msg_in = bus_if_pkg::mem_resp;
            @(negedge clock);
            bus_msg_in = bus_if_pkg::no_req;
        end else begin
            repeat (rows[idx].resp_delay) @(negedge clock);
            bus_msg_in  = bus_if_pkg::mem_resp;
            bus_data_in = flat[63:0];
            @(negedge clock);
            bus_msg_in  = bus_if_pkg::no_req;
            bus_data_in = flat[127:64];
            @(negedge clock);
            bus_data_in = '0;
        end
    endtask

    // drops the strobe and sends the other request while the DUT is busy
    task automatic stray_strobe(input int idx);
        @(negedge clock);
        cache_msg_in = bus_if_pkg::no_req;
        if (rows[idx].stray) begin
            @(negedge clock);
            cache_msg_in     = (rows[idx].msg == bus_if_pkg::wb_req) ? bus_if_pkg::r_req
                                                                    : bus_if_pkg::wb_req;
            cache_address_in = rows[idx].address ^ 32'h0000_f000;
            cache_data_in    = ~rows[idx].data;
            @(negedge clock);
            cache_msg_in     = bus_if_pkg::no_req;
        end
    endtask

    task automatic watch_row(input int idx);
        logic [127:0] flat;
        logic [63:0]  beats [$];
        bit           is_wb;
        bit           completed;
        int           cycle;
        int           first_beat;
        int           second_beat;
        int           pulses;
        int           tail;
        int           done_cycle;
        flat        = rows[idx].data;
        is_wb       = (rows[idx].msg == bus_if_pkg::wb_req);
        completed   = 1'b0;
        cycle       = 0;
        first_beat  = -1;
        second_beat = -1;
        pulses      = 0;
        tail        = 0;
        done_cycle  = rows[idx].grant_delay + rows[idx].resp_delay + 6;
        while (!(completed && tail == 2)) begin
            @(negedge clock);
            cycle++;
            if (bus_data_out != '0) begin
                if (beats.size() == 0) begin
                    first_beat = cycle;
                end
                second_beat = cycle;
                beats.push_back(bus_data_out);
            end
            if (cache_msg_out == bus_if_pkg::mem_resp) begin
                pulses++;
                if (!completed) begin
                    check_value("completion cycle", cycle, done_cycle);
                    check_value("cache_address_out", cache_address_out, rows[idx].address);
                    check_value("cache_data_out", cache_data_out, is_wb ? 128'h0 : flat);
                    completed = 1'b1;
                end
            end else if (completed) begin
                tail++;
            end
            if (completed) begin
                check_value("bus_msg_out", bus_msg_out, bus_if_pkg::no_req);
            end else if (cycle >= 2) begin  // request holds from one cycle after the strobe
                check_value("bus_msg_out", bus_msg_out, rows[idx].msg);
                check_value("bus_address_out", bus_address_out, rows[idx].address);
            end
        end
        check_value("cache_msg_out pulses", pulses, 1);
        check_value("bus_data_out beats", beats.size(), is_wb ? 2 : 0);
        if (is_wb && beats.size() == 2) begin
            check_value("first beat cycle", first_beat, rows[idx].grant_delay + 4);
            check_value("second beat cycle", second_beat, rows[idx].grant_delay + 5);
            check_value("bus_data_out", beats[0], flat[63:0]);    // words 0 and 1
            check_value("bus_data_out", beats[1], flat[127:64]);  // words 2 and 3
        end
    endtask

    task automatic run_row(input int idx);
        row_errors = 0;
        @(negedge clock);
        cache_msg_in     = rows[idx].msg;
        cache_address_in = rows[idx].address;
        cache_data_in    = rows[idx].data;
        fork
            respond_row(idx);
            stray_strobe(idx);
            watch_row(idx);
        join
        $display("row %0d %s at %h: %s", idx,
                 (rows[idx].msg == bus_if_pkg::wb_req) ? "write-back" : "read",
                 rows[idx].address, (row_errors == 0) ? "ok" : "failed");
    endtask

    initial begin
        reset            = 1'b1;
        cache_msg_in     = bus_if_pkg::no_req;
        cache_address_in = '0;
        cache_data_in    = '0;
        bus_msg_in       = bus_if_pkg::no_req;
        bus_data_in      = '0;
        bus_master       = 1'b0;
        lfsr_state       = lfsr_width'(77);

        set_row(0, bus_if_pkg::wb_req, 32'h0000_1000, 0, 0, 1'b0);
        set_row(1, bus_if_pkg::r_req,  32'h0000_2040, 0, 0, 1'b0);
        set_row(2, bus_if_pkg::wb_req, 32'h8000_00c0, 3, 2, 1'b1);
        set_row(3, bus_if_pkg::r_req,  32'h1234_5670, 2, 4, 1'b1);
        set_row(4, bus_if_pkg::r_req,  32'h0000_0010, 1, 0, 1'b0);
        set_row(5, bus_if_pkg::wb_req, 32'hffff_fff0, 5, 1, 1'b0);

        cycle_limit = reset_cycles + timeout_margin;
        for (int i = 0; i < num_rows; i++) begin
            cycle_limit += rows[i].grant_delay + rows[i].resp_delay + 10;
        end

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        row_errors = 0;
        check_value("cache_msg_out", cache_msg_out, bus_if_pkg::no_req);
        check_value("bus_msg_out", bus_msg_out, bus_if_pkg::no_req);
        check_value("cache_address_out", cache_address_out, '0);
        check_value("bus_address_out", bus_address_out, '0);
        check_value("cache_data_out", cache_data_out, '0);
        check_value("bus_data_out", bus_data_out, '0);
        $display("reset values: %s", (row_errors == 0) ? "ok" : "failed");

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end

        $display("rows %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/bus_if_pkg.sv */
// bus interface package with line geometry constants, bus message codes and data types
package bus_if_pkg;

    // line and bus geometry, fixed for this build
    localparam int word_width     = 32;
    localparam int address_width  = 32;
    localparam int msg_width      = 4;
    localparam int line_words     = 4;                        // words per cache line
    localparam int beat_words     = 2;                        // words per bus beat
    localparam int beats_per_line = line_words / beat_words;

    // message codes seen on both the cache and the bus side
    typedef enum logic [msg_width-1:0] {
        no_req   = 4'd0,
        r_req    = 4'd1,  // line read
        wb_req   = 4'd2,  // line write-back
        mem_resp = 4'd3   // completion from memory
    } msg_t;

    typedef logic [word_width-1:0] word_t;

    // word 0 sits in the low bits of both the line and the beat
    typedef word_t [line_words-1:0] line_t;
    typedef word_t [beat_words-1:0] beat_t;

    // index of a beat within a line
    typedef logic [$clog2(beats_per_line)-1:0] beat_count_t;

endpackage

/* src/l1_bus_interface.sv */
// top level of the cache-side bus interface: sequencer plus line serializer and deserializer
`timescale 1ns/10ps

module l1_bus_interface (
    input  logic                                  clock,
    input  logic                                  reset,
    input  bus_if_pkg::msg_t                      cache_msg_in,
    input  logic [bus_if_pkg::address_width-1:0]  cache_address_in,
    input  bus_if_pkg::line_t                     cache_data_in,
    output bus_if_pkg::msg_t                      cache_msg_out,
    output logic [bus_if_pkg::address_width-1:0]  cache_address_out,
    output bus_if_pkg::line_t                     cache_data_out,
    input  bus_if_pkg::msg_t                      bus_msg_in,
    input  bus_if_pkg::beat_t                     bus_data_in,
    input  logic                                  bus_master,
    output bus_if_pkg::msg_t                      bus_msg_out,
    output logic [bus_if_pkg::address_width-1:0]  bus_address_out,
    output bus_if_pkg::beat_t                     bus_data_out
);

    logic               load_line;
    logic               send_beat;
    logic               take_beat;
    logic               ser_last_beat;
    logic               des_last_beat;
    logic               line_ready;
    bus_if_pkg::line_t  assembled_line;

    request_sequencer i_request_sequencer (
        .clock             (clock),
        .reset             (reset),
        .cache_msg_in      (cache_msg_in),
        .cache_address_in  (cache_address_in),
        .bus_msg_in        (bus_msg_in),
        .bus_master        (bus_master),
        .ser_last_beat     (ser_last_beat),
        .des_last_beat     (des_last_beat),
        .load_line         (load_line),
        .send_beat         (send_beat),
        .take_beat         (take_beat),
        .cache_msg_out     (cache_msg_out),
        .cache_address_out (cache_address_out),
        .bus_msg_out       (bus_msg_out),
        .bus_address_out   (bus_address_out),
        .line_ready        (line_ready)
    );

    // write-back path, cache line out to the bus
    line_serializer i_line_serializer (
        .clock     (clock),
        .reset     (reset),
        .load_line (load_line),
        .send_beat (send_beat),
        .line      (cache_data_in),
        .beat      (bus_data_out),
        .last_beat (ser_last_beat)
    );

    // read path, bus beats in to a cache line
    line_deserializer i_line_deserializer (
        .clock     (clock),
        .reset     (reset),
        .take_beat (take_beat),
        .beat      (bus_data_in),
        .line      (assembled_line),
        .last_beat (des_last_beat)
    );

    // the line shows only with a read completion, a write-back returns zero
    assign cache_data_out = line_ready ? assembled_line : '0;

endmodule

/* src/line_deserializer.sv */
// line deserializer that gathers consecutive bus beats into a cache line
`timescale 1ns/10ps

module line_deserializer (
    input  logic               clock,
    input  logic               reset,
    input  logic               take_beat,
    input  bus_if_pkg::beat_t  beat,
    output bus_if_pkg::line_t  line,
    output logic               last_beat
);

    bus_if_pkg::beat_count_t count;

    // each beat lands in the slot picked by the counter, beat 0 lowest
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            line  <= '0;
        end else if (take_beat) begin
            line[count*bus_if_pkg::beat_words +: bus_if_pkg::beat_words] <= beat;
            count <= count + 1'b1;  // wraps to 0 after the final beat
        end
    end

    assign last_beat = (count == bus_if_pkg::beat_count_t'(bus_if_pkg::beats_per_line - 1));

endmodule

/* src/line_serializer.sv */
// line serializer that holds a cache line and sends it out one bus beat at a time
`timescale 1ns/10ps

module line_serializer (
    input  logic               clock,
    input  logic               reset,
    input  logic               load_line,
    input  logic               send_beat,
    input  bus_if_pkg::line_t  line,
    output bus_if_pkg::beat_t  beat,
    output logic               last_beat
);

    bus_if_pkg::line_t        line_q;
    bus_if_pkg::beat_count_t  count;

    always_ff @(posedge clock) begin
        if (load_line) begin
            line_q <= line;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            beat  <= '0;
        end else begin
            if (load_line) begin
                count <= '0;  // restart at beat 0 for each new line
            end else if (send_beat) begin
                count <= count + 1'b1;
            end

            // bus data is zero whenever no beat is being sent
            if (send_beat) begin
                beat <= line_q[count*bus_if_pkg::beat_words +: bus_if_pkg::beat_words];
            end else begin
                beat <= '0;
            end
        end
    end

    assign last_beat = (count == bus_if_pkg::beat_count_t'(bus_if_pkg::beats_per_line - 1));

    // once the last beat is out nothing more is sent before a new line is loaded
    assert property (@(posedge clock) disable iff (reset)
        (send_beat && last_beat) |=> (!send_beat until load_line));

endmodule

/* src/request_sequencer.sv */
// transaction FSM that captures cache requests and drives the bus and completion messages
`timescale 1ns/10ps

module request_sequencer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  bus_if_pkg::msg_t                      cache_msg_in,
    input  logic [bus_if_pkg::address_width-1:0]  cache_address_in,
    input  bus_if_pkg::msg_t                      bus_msg_in,
    input  logic                                  bus_master,
    input  logic                                  ser_last_beat,
    input  logic                                  des_last_beat,
    output logic                                  load_line,
    output logic                                  send_beat,
    output logic                                  take_beat,
    output bus_if_pkg::msg_t                      cache_msg_out,
    output logic [bus_if_pkg::address_width-1:0]  cache_address_out,
    output bus_if_pkg::msg_t                      bus_msg_out,
    output logic [bus_if_pkg::address_width-1:0]  bus_address_out,
    output logic                                  line_ready
);

    typedef enum logic [2:0] {
        idle,
        issue,
        wait_for_bus,
        transfer,
        wait_resp,
        receive,
        done
    } state_t;

    state_t                                state;
    bus_if_pkg::msg_t                      req_msg;
    logic [bus_if_pkg::address_width-1:0]  req_address;
    logic                                  request;
    logic                                  is_wb;
    logic                                  resp_seen;

    assign request   = (cache_msg_in == bus_if_pkg::r_req) ||
                       (cache_msg_in == bus_if_pkg::wb_req);
    assign is_wb     = (req_msg == bus_if_pkg::wb_req);
    assign resp_seen = (bus_msg_in == bus_if_pkg::mem_resp);

    // only a write-back needs the line from the cache
    assign load_line = (state == idle) && (cache_msg_in == bus_if_pkg::wb_req);
    assign send_beat = (state == transfer);
    // beat 0 comes with the first mem_resp and the rest follow back to back
    assign take_beat = ((state == wait_resp) && !is_wb && resp_seen) || (state == receive);

    always_ff @(posedge clock) begin
        if (state == idle && request) begin
            req_address <= cache_address_in;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= idle;
            req_msg           <= bus_if_pkg::no_req;
            cache_msg_out     <= bus_if_pkg::no_req;
            cache_address_out <= '0;
            bus_msg_out       <= bus_if_pkg::no_req;
            bus_address_out   <= '0;
            line_ready        <= 1'b0;
        end else begin
            // completion outputs last one cycle only
            cache_msg_out     <= bus_if_pkg::no_req;
            cache_address_out <= '0;
            line_ready        <= 1'b0;

            case (state)
                idle: begin
                    if (request) begin  // strobes while busy are simply dropped
                        req_msg <= cache_msg_in;
                        state   <= issue;
                    end
                end
                issue: begin
                    bus_msg_out     <= req_msg;
                    bus_address_out <= req_address;
                    state           <= wait_for_bus;
                end
                wait_for_bus: begin
                    if (bus_master) begin
                        state <= is_wb ? transfer : wait_resp;
                    end
                end
                transfer: begin
                    if (ser_last_beat) begin
                        state <= wait_resp;
                    end
                end
                wait_resp: begin
                    if (resp_seen) begin
                        if (is_wb) begin  // ack after the last beat ends the write-back
                            cache_msg_out     <= bus_if_pkg::mem_resp;
                            cache_address_out <= req_address;
                            bus_msg_out       <= bus_if_pkg::no_req;
                            bus_address_out   <= '0;
                            state             <= idle;
                        end else begin
                            state <= receive;
                        end
                    end
                end
                receive: begin
                    if (des_last_beat) begin
                        state <= done;
                    end
                end
                done: begin
                    // line is complete in the deserializer now
                    cache_msg_out     <= bus_if_pkg::mem_resp;
                    cache_address_out <= req_address;
                    line_ready        <= 1'b1;
                    bus_msg_out       <= bus_if_pkg::no_req;
                    bus_address_out   <= '0;
                    state             <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // the captured request stays put on the bus until the grant arrives
    assert property (@(posedge clock) disable iff (reset)
        (state == wait_for_bus) |->
            ((bus_msg_out == req_msg) && (bus_address_out == req_address)));

    // no read data is taken from write-back acceptance until back in idle
    assert property (@(posedge clock) disable iff (reset)
        load_line |=> (!take_beat until (state == idle)));

endmodule

/* tb.f */
src/bus_if_pkg.sv
src/line_serializer.sv
src/line_deserializer.sv
src/request_sequencer.sv
src/l1_bus_interface.sv
bench/tb_l1_bus_interface.sv
